// File: verilog.f
hw/rammodel_pkg.sv
hw/ready_valid_fork.sv
hw/rammodel_tracker.sv
hw/rammodel_tm_fixed.sv
hw/rammodel_frontend.sv
hw/rammodel_backend.sv
hw/rammodel_top.sv
bench/clock_gen.sv
bench/rammodel_sva.sv
bench/rammodel_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI memory model testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --top-module rammodel_tb \
    --Mdir obj_dir -o rammodel_sim -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rammodel_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

// File: bench/rammodel_tb.sv
module rammodel_tb;
    import rammodel_pkg::*;

    localparam int MAX_INFLIGHT = 8;
    localparam int R_DELAY      = 25;
    localparam int W_DELAY      = 3;
    localparam int MEM_WORDS    = 1024;
    localparam int WORD_SHIFT   = $clog2(DATA_W / 8);
    localparam int N_BURSTS     = 6;
    localparam int N_OPS        = 1 + 3 * N_BURSTS + MAX_INFLIGHT + 3;   // Reset counts as one

    logic    clk;
    logic    rst_n;
    logic    aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
    logic    b_valid, b_ready, r_valid, r_ready;
    axi_ax_t aw, ar;
    axi_w_t  w;
    axi_b_t  b;
    axi_r_t  r;
    logic    aw_hs, w_hs, ar_hs;

    data_t   ref_mem [MEM_WORDS];
    addr_t   base_q  [N_BURSTS];
    int      beats_q [N_BURSTS];
    id_t     exp_bid[$];
    id_t     exp_rid[$];
    addr_t   exp_raddr[$];
    len_t    exp_rlen[$];
    len_t    r_beat = '0;
    integer  seed;
    int      k;
    int      checks = 0;
    int      errors = 0;

    clock_gen #(.PERIOD(100), .RESET_CYCLES(10)) u_clock_gen (.clk(clk), .rst_n(rst_n));

    rammodel_top #(
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .R_DELAY      (R_DELAY),
        .W_DELAY      (W_DELAY),
        .MEM_WORDS    (MEM_WORDS)
    ) u_rammodel_top (
        .clk, .rst_n,
        .aw_valid, .aw_ready, .aw,
        .w_valid, .w_ready, .w,
        .ar_valid, .ar_ready, .ar,
        .b_valid, .b_ready, .b,
        .r_valid, .r_ready, .r
    );

    bind rammodel_top rammodel_sva #(
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .R_DELAY      (R_DELAY),
        .W_DELAY      (W_DELAY)
    ) u_sva (
        .clk(clk), .rst_n(rst_n),
        .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w_valid(w_valid), .w_ready(w_ready), .w(w),
        .ar_valid(ar_valid), .ar_ready(ar_ready),
        .b_valid(b_valid), .b_ready(b_ready), .b(b),
        .r_valid(r_valid), .r_ready(r_ready), .r(r)
    );

    function automatic int mem_index(input addr_t addr, input len_t beat);
        return (int'(addr >> WORD_SHIFT) + int'(beat)) % MEM_WORDS;
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t res;
        int    i;
        res = old_word;
        for (i = 0; i < DATA_W / 8; i++) begin
            if (strb[i]) res[8*i +: 8] = new_word[8*i +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("FAILED at time %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // Handshakes seen at the last rising edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_hs <= 1'b0;
            w_hs  <= 1'b0;
            ar_hs <= 1'b0;
        end else begin
            aw_hs <= aw_valid && aw_ready;
            w_hs  <= w_valid && w_ready;
            ar_hs <= ar_valid && ar_ready;
        end
    end

    always @(posedge clk) begin
        if (rst_n && r_valid && r_ready) begin
            if (exp_rid.size() == 0) begin
                $display("R beat at time %0t while no read was outstanding", $time);
                errors++;
            end else begin
                check_value(r.id == exp_rid[0], "R id out of request order");
                check_value(r.data === ref_mem[mem_index(exp_raddr[0], r_beat)],
                            "R data differs from reference memory");
                check_value(r.last == (r_beat == exp_rlen[0]), "rlast on the wrong beat");
                if (r_beat == exp_rlen[0]) begin
                    r_beat = '0;
                    void'(exp_rid.pop_front());
                    void'(exp_raddr.pop_front());
                    void'(exp_rlen.pop_front());
                end else begin
                    r_beat = r_beat + 8'd1;
                end
            end
        end
        if (rst_n && b_valid && b_ready) begin
            if (exp_bid.size() == 0) begin
                $display("B at time %0t while no write was outstanding", $time);
                errors++;
            end else begin
                check_value(b.id == exp_bid[0], "B id out of request order");
                void'(exp_bid.pop_front());
            end
        end
    end

    task automatic write_burst(input id_t id, input addr_t addr, input int beats,
                               input logic full_strb, input int b_hold);
        axi_ax_t ax;
        axi_w_t  beat;
        int      i;
        ax = '{id: id, addr: addr, len: len_t'(beats - 1), size: 3'd2, burst: 2'b01};
        exp_bid.push_back(id);
        b_ready = (b_hold == 0);
        @(negedge clk);
        aw       = ax;
        aw_valid = 1'b1;
        do @(negedge clk); while (!aw_hs);
        aw_valid = 1'b0;
        for (i = 0; i < beats; i++) begin
            beat.data = data_t'($random(seed));
            beat.strb = full_strb ? '1 : strb_t'($random(seed));
            beat.last = (i == beats - 1);
            w         = beat;
            w_valid   = 1'b1;
            do @(negedge clk); while (!w_hs);
            ref_mem[mem_index(addr, len_t'(i))] =
                merge_bytes(ref_mem[mem_index(addr, len_t'(i))], beat.data, beat.strb);
        end
        w_valid = 1'b0;
        if (b_hold > 0) begin
            while (!b_valid) @(negedge clk);
            repeat (b_hold) @(negedge clk);   // Response held off
            b_ready = 1'b1;
        end
        while (exp_bid.size() != 0) @(negedge clk);
    endtask

    task automatic read_burst(input id_t id, input addr_t addr, input int beats);
        axi_ax_t ax;
        ax = '{id: id, addr: addr, len: len_t'(beats - 1), size: 3'd2, burst: 2'b01};
        exp_rid.push_back(id);
        exp_raddr.push_back(addr);
        exp_rlen.push_back(ax.len);
        @(negedge clk);
        ar       = ax;
        ar_valid = 1'b1;
        do @(negedge clk); while (!ar_hs);
        ar_valid = 1'b0;
    endtask

    task automatic wait_reads_done;
        while (exp_rid.size() != 0) @(negedge clk);
    endtask

    initial begin
        seed     = 87;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        ar_valid = 1'b0;
        ar       = '0;
        b_ready  = 1'b1;
        r_ready  = 1'b1;
        @(posedge rst_n);
        repeat (3) @(negedge clk);

        // Full write, masked overwrite, read back
        for (k = 0; k < N_BURSTS; k++) begin
            beats_q[k] = ($random(seed) & 7) + 1;
            base_q[k]  = addr_t'(((k * 16) + ($random(seed) & 7)) << WORD_SHIFT);
            write_burst(id_t'(2 * k), base_q[k], beats_q[k], 1'b1, 0);
            write_burst(id_t'(2 * k + 1), base_q[k], beats_q[k], 1'b0, 0);
            read_burst(id_t'(k + 8), base_q[k], beats_q[k]);
            wait_reads_done();
        end

        // Fill every read slot with rready low
        r_ready = 1'b0;
        for (k = 0; k < MAX_INFLIGHT; k++) begin
            read_burst(id_t'(k), base_q[k % N_BURSTS], beats_q[k % N_BURSTS]);
        end
        fork
            read_burst(id_t'(MAX_INFLIGHT), base_q[0], beats_q[0]);
            begin
                repeat (R_DELAY + 10) @(negedge clk);
                r_ready = 1'b1;
            end
        join
        wait_reads_done();

        write_burst(id_t'(3), base_q[1], beats_q[1], 1'b0, 4);
        read_burst(id_t'(5), base_q[1], beats_q[1]);
        wait_reads_done();

        repeat (5) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (N_OPS * (R_DELAY + 20)) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", N_OPS * (R_DELAY + 20));
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: bench/rammodel_sva.sv
module rammodel_sva #(
    parameter int MAX_INFLIGHT = 8,
    parameter int R_DELAY      = 25,
    parameter int W_DELAY      = 3
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 aw_valid,
    input logic                 aw_ready,
    input logic                 w_valid,
    input logic                 w_ready,
    input rammodel_pkg::axi_w_t w,
    input logic                 ar_valid,
    input logic                 ar_ready,
    input logic                 b_valid,
    input logic                 b_ready,
    input rammodel_pkg::axi_b_t b,
    input logic                 r_valid,
    input logic                 r_ready,
    input rammodel_pkg::axi_r_t r
);
    import rammodel_pkg::*;

    logic [7:0] rd_out;   // Reads accepted, last beat not yet taken
    logic [7:0] wr_out;   // Writes accepted, B not yet taken
    logic       ar_hs, aw_hs, wl_hs, b_hs, r_end;

    assign ar_hs = ar_valid && ar_ready;
    assign aw_hs = aw_valid && aw_ready;
    assign wl_hs = w_valid && w_ready && w.last;
    assign b_hs  = b_valid && b_ready;
    assign r_end = r_valid && r_ready && r.last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_out <= '0;
            wr_out <= '0;
        end else begin
            rd_out <= rd_out + 8'(ar_hs) - 8'(r_end);
            wr_out <= wr_out + 8'(aw_hs) - 8'(b_hs);
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !b_valid && !r_valid)
        else $error("Response valid during reset");
    a_r_needs_ar: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid |-> rd_out != '0) else $error("R valid with no read outstanding");
    a_b_needs_aw: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid |-> wr_out != '0) else $error("B valid with no write outstanding");
    a_ar_limit: assert property (@(posedge clk) disable iff (!rst_n)
        rd_out == 8'(MAX_INFLIGHT) |-> !ar_ready) else $error("AR accepted past the limit");
    a_r_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ar_hs && rd_out == '0 |-> ##R_DELAY $rose(r_valid))
        else $error("First R beat not at the read latency");
    a_b_latency: assert property (@(posedge clk) disable iff (!rst_n)
        wl_hs && wr_out == 8'd1 |-> ##W_DELAY $rose(b_valid))
        else $error("B not at the write latency");
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r)) else $error("R changed while stalled");
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid && $stable(b)) else $error("B changed while stalled");
    a_r_okay: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid |-> r.resp == RESP_OKAY) else $error("R response not OKAY");
    a_b_okay: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid |-> b.resp == RESP_OKAY) else $error("B response not OKAY");

endmodule

// File: bench/clock_gen.sv
module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: hw/rammodel_top.sv
module rammodel_top #(
    parameter int MAX_INFLIGHT = 8,
    parameter int R_DELAY      = 25,
    parameter int W_DELAY      = 3,
    parameter int MEM_WORDS    = 1024
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  rammodel_pkg::axi_ax_t aw,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  rammodel_pkg::axi_w_t  w,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  rammodel_pkg::axi_ax_t ar,
    output logic                  b_valid,
    input  logic                  b_ready,
    output rammodel_pkg::axi_b_t  b,
    output logic                  r_valid,
    input  logic                  r_ready,
    output rammodel_pkg::axi_r_t  r
);
    import rammodel_pkg::*;

    logic      areq_valid;
    logic      wreq_valid;
    logic      rreq_valid;
    logic      rreq_last;
    mem_areq_t areq;
    mem_wreq_t wreq;
    data_t     rreq_data;

    rammodel_frontend #(
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .R_DELAY      (R_DELAY),
        .W_DELAY      (W_DELAY)
    ) u_frontend (
        .clk, .rst_n,
        .aw_valid, .aw_ready, .aw,
        .w_valid, .w_ready, .w,
        .ar_valid, .ar_ready, .ar,
        .b_valid, .b_ready, .b,
        .r_valid, .r_ready, .r,
        .areq_valid, .areq,
        .wreq_valid, .wreq,
        .rreq_valid,
        .rreq_id   (),    // Backend serves reads strictly in order
        .rreq_data, .rreq_last
    );

    rammodel_backend #(.MEM_WORDS(MEM_WORDS)) u_backend (
        .clk, .rst_n,
        .areq_valid, .areq,
        .wreq_valid, .wreq,
        .rreq_valid, .rreq_data, .rreq_last
    );

endmodule

// File: hw/rammodel_backend.sv
module rammodel_backend #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    areq_valid,
    input  rammodel_pkg::mem_areq_t areq,
    input  logic                    wreq_valid,
    input  rammodel_pkg::mem_wreq_t wreq,
    input  logic                    rreq_valid,
    output rammodel_pkg::data_t     rreq_data,
    output logic                    rreq_last
);
    import rammodel_pkg::*;

    localparam int QDEPTH     = 16;
    localparam int WORD_SHIFT = $clog2(DATA_W / 8);
    localparam int MIDX       = $clog2(MEM_WORDS);

    typedef logic [$clog2(QDEPTH)-1:0] qptr_t;

    data_t mem     [MEM_WORDS];
    addr_t wq_addr [QDEPTH];
    addr_t rq_addr [QDEPTH];
    len_t  rq_len  [QDEPTH];
    qptr_t wq_wp, wq_rp, rq_wp, rq_rp;
    len_t  w_beat, r_beat;
    addr_t w_word, r_word;

    // INCR only, one full word per beat
    assign w_word    = (wq_addr[wq_rp] >> WORD_SHIFT) + addr_t'(w_beat);
    assign r_word    = (rq_addr[rq_rp] >> WORD_SHIFT) + addr_t'(r_beat);
    assign rreq_data = mem[r_word[MIDX-1:0]];
    assign rreq_last = r_beat == rq_len[rq_rp];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wq_wp  <= '0;
            wq_rp  <= '0;
            rq_wp  <= '0;
            rq_rp  <= '0;
            w_beat <= '0;
            r_beat <= '0;
        end else begin
            if (areq_valid && areq.write) begin
                wq_wp <= wq_wp + 1'b1;
            end
            if (areq_valid && !areq.write) begin
                rq_wp <= rq_wp + 1'b1;
            end
            if (wreq_valid) begin
                w_beat <= wreq.last ? '0 : w_beat + 1'b1;
                if (wreq.last) begin
                    wq_rp <= wq_rp + 1'b1;
                end
            end
            if (rreq_valid) begin
                r_beat <= rreq_last ? '0 : r_beat + 1'b1;
                if (rreq_last) begin
                    rq_rp <= rq_rp + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (areq_valid && areq.write) begin
            wq_addr[wq_wp] <= areq.ax.addr;
        end
        if (areq_valid && !areq.write) begin
            rq_addr[rq_wp] <= areq.ax.addr;
            rq_len[rq_wp]  <= areq.ax.len;
        end
        if (wreq_valid) begin
            for (int i = 0; i < DATA_W / 8; i++) begin
                if (wreq.strb[i]) begin
                    mem[w_word[MIDX-1:0]][8*i +: 8] <= wreq.data[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: hw/rammodel_frontend.sv
module rammodel_frontend #(
    parameter int MAX_INFLIGHT = 8,
    parameter int R_DELAY      = 25,
    parameter int W_DELAY      = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  rammodel_pkg::axi_ax_t   aw,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  rammodel_pkg::axi_w_t    w,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  rammodel_pkg::axi_ax_t   ar,
    output logic                    b_valid,
    input  logic                    b_ready,
    output rammodel_pkg::axi_b_t    b,
    output logic                    r_valid,
    input  logic                    r_ready,
    output rammodel_pkg::axi_r_t    r,
    output logic                    areq_valid,
    output rammodel_pkg::mem_areq_t areq,
    output logic                    wreq_valid,
    output rammodel_pkg::mem_wreq_t wreq,
    output logic                    rreq_valid,
    output rammodel_pkg::id_t       rreq_id,
    input  rammodel_pkg::data_t     rreq_data,
    input  logic                    rreq_last
);
    import rammodel_pkg::*;

    logic trk_aw_valid, trk_aw_ready, tm_aw_valid, tm_aw_ready;
    logic trk_w_valid, trk_w_ready, tm_w_valid, tm_w_ready;
    logic trk_ar_valid, trk_ar_ready, tm_ar_valid, tm_ar_ready;
    logic trk_b_valid, trk_b_ready, tm_b_valid, tm_b_ready;
    logic trk_r_valid, trk_r_ready, tm_r_valid, tm_r_ready;
    id_t  tm_b_id, tm_r_id;

    // Requests go to both the tracker and the timing model
    ready_valid_fork #(.BRANCHES(2)) u_fork_aw (
        .clk, .rst_n, .s_valid(aw_valid), .s_ready(aw_ready),
        .m_valid({tm_aw_valid, trk_aw_valid}), .m_ready({tm_aw_ready, trk_aw_ready})
    );
    ready_valid_fork #(.BRANCHES(2)) u_fork_w (
        .clk, .rst_n, .s_valid(w_valid), .s_ready(w_ready),
        .m_valid({tm_w_valid, trk_w_valid}), .m_ready({tm_w_ready, trk_w_ready})
    );
    ready_valid_fork #(.BRANCHES(2)) u_fork_ar (
        .clk, .rst_n, .s_valid(ar_valid), .s_ready(ar_ready),
        .m_valid({tm_ar_valid, trk_ar_valid}), .m_ready({tm_ar_ready, trk_ar_ready})
    );

    rammodel_tracker #(.MAX_INFLIGHT(MAX_INFLIGHT)) u_tracker (
        .clk, .rst_n,
        .aw_valid   (trk_aw_valid),
        .aw_ready   (trk_aw_ready),
        .aw         (aw),
        .w_valid    (trk_w_valid),
        .w_ready    (trk_w_ready),
        .w          (w),
        .ar_valid   (trk_ar_valid),
        .ar_ready   (trk_ar_ready),
        .ar         (ar),
        .b_valid    (trk_b_valid),
        .b_ready    (trk_b_ready),
        .r_valid    (trk_r_valid),
        .r_ready    (trk_r_ready),
        .r          (r),
        .areq_valid, .areq, .wreq_valid, .wreq
    );

    rammodel_tm_fixed #(
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .R_DELAY      (R_DELAY),
        .W_DELAY      (W_DELAY)
    ) u_timing_model (
        .clk, .rst_n,
        .ar_valid   (tm_ar_valid),
        .ar_ready   (tm_ar_ready),
        .ar         (ar),
        .aw_valid   (tm_aw_valid),
        .aw_ready   (tm_aw_ready),
        .aw         (aw),
        .w_valid    (tm_w_valid),
        .w_ready    (tm_w_ready),
        .w_last     (w.last),
        .b_valid    (tm_b_valid),
        .b_ready    (tm_b_ready),
        .b_id       (tm_b_id),
        .r_valid    (tm_r_valid),
        .r_ready    (tm_r_ready),
        .r_id       (tm_r_id)
    );

    // Responses go to the target and back to the tracker
    ready_valid_fork #(.BRANCHES(2)) u_fork_b (
        .clk, .rst_n, .s_valid(tm_b_valid), .s_ready(tm_b_ready),
        .m_valid({b_valid, trk_b_valid}), .m_ready({b_ready, trk_b_ready})
    );
    ready_valid_fork #(.BRANCHES(2)) u_fork_r (
        .clk, .rst_n, .s_valid(tm_r_valid), .s_ready(tm_r_ready),
        .m_valid({r_valid, trk_r_valid}), .m_ready({r_ready, trk_r_ready})
    );

    assign b = '{id: tm_b_id, resp: RESP_OKAY};
    assign r = '{id: tm_r_id, data: rreq_data, resp: RESP_OKAY, last: rreq_last};

    assign rreq_valid = tm_r_valid && tm_r_ready;   // Backend moves to next beat
    assign rreq_id    = tm_r_id;

endmodule

// File: hw/rammodel_tm_fixed.sv
module rammodel_tm_fixed #(
    parameter int MAX_INFLIGHT = 8,
    parameter int R_DELAY      = 25,
    parameter int W_DELAY      = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  rammodel_pkg::axi_ax_t ar,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  rammodel_pkg::axi_ax_t aw,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  logic                  w_last,
    output logic                  b_valid,
    input  logic                  b_ready,
    output rammodel_pkg::id_t     b_id,
    output logic                  r_valid,
    input  logic                  r_ready,
    output rammodel_pkg::id_t     r_id
);
    import rammodel_pkg::*;

    localparam int IW = $clog2(MAX_INFLIGHT);

    typedef logic [IW-1:0] idx_t;
    typedef logic [15:0]   stamp_t;
    typedef enum logic [1:0] {r_idle, r_wait, r_burst} r_state_t;

    stamp_t now;    // Free-running cycle count

    id_t      rd_id  [MAX_INFLIGHT];
    len_t     rd_len [MAX_INFLIGHT];
    stamp_t   rd_due [MAX_INFLIGHT];
    logic [MAX_INFLIGHT-1:0] rd_vld;
    idx_t     rd_wp, rd_rp;
    len_t     r_beat;
    r_state_t r_state;
    stamp_t   rd_age;
    logic     ar_fire, r_fire, r_last;

    id_t      wr_id  [MAX_INFLIGHT];
    stamp_t   wr_due [MAX_INFLIGHT];
    logic [MAX_INFLIGHT-1:0] has_aw, has_w;
    idx_t     aw_wp, w_wp, b_rp;
    stamp_t   wr_age;
    logic     aw_fire, wl_fire, b_fire;

    function automatic idx_t nxt(idx_t p);
        return (p == idx_t'(MAX_INFLIGHT - 1)) ? '0 : p + 1'b1;
    endfunction

    assign ar_ready = !rd_vld[rd_wp];
    assign ar_fire  = ar_valid && ar_ready;
    assign rd_age   = now - rd_due[rd_rp];   // Sign bit clear once due
    assign r_valid  = rd_vld[rd_rp] && (r_state == r_burst || !rd_age[15]);
    assign r_id     = rd_id[rd_rp];
    assign r_fire   = r_valid && r_ready;
    assign r_last   = r_beat == rd_len[rd_rp];

    // W for a slot is taken only after its AW
    assign aw_ready = !has_aw[aw_wp];
    assign aw_fire  = aw_valid && aw_ready;
    assign w_ready  = has_aw[w_wp] && !has_w[w_wp];
    assign wl_fire  = w_valid && w_ready && w_last;
    assign wr_age   = now - wr_due[b_rp];
    assign b_valid  = has_w[b_rp] && !wr_age[15];
    assign b_id     = wr_id[b_rp];
    assign b_fire   = b_valid && b_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            now     <= '0;
            rd_vld  <= '0;
            rd_wp   <= '0;
            rd_rp   <= '0;
            r_beat  <= '0;
            r_state <= r_idle;
        end else begin
            now <= now + 1'b1;
            if (ar_fire) begin
                rd_vld[rd_wp] <= 1'b1;
                rd_wp         <= nxt(rd_wp);
            end
            if (r_fire) begin
                r_beat  <= r_last ? '0 : r_beat + 1'b1;
                r_state <= r_last ? r_idle : r_burst;
                if (r_last) begin
                    rd_vld[rd_rp] <= 1'b0;
                    rd_rp         <= nxt(rd_rp);
                end
            end else if (r_state == r_idle && rd_vld[rd_rp]) begin
                r_state <= r_wait;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            has_aw <= '0;
            has_w  <= '0;
            aw_wp  <= '0;
            w_wp   <= '0;
            b_rp   <= '0;
        end else begin
            if (aw_fire) begin
                has_aw[aw_wp] <= 1'b1;
                aw_wp         <= nxt(aw_wp);
            end
            if (wl_fire) begin
                has_w[w_wp] <= 1'b1;
                w_wp        <= nxt(w_wp);
            end
            if (b_fire) begin
                has_aw[b_rp] <= 1'b0;
                has_w[b_rp]  <= 1'b0;
                b_rp         <= nxt(b_rp);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_id[rd_wp]  <= ar.id;
            rd_len[rd_wp] <= ar.len;
            rd_due[rd_wp] <= now + stamp_t'(R_DELAY);
        end
        if (aw_fire) begin
            wr_id[aw_wp] <= aw.id;
        end
        if (wl_fire) begin
            wr_due[w_wp] <= now + stamp_t'(W_DELAY);
        end
    end

endmodule

// File: hw/rammodel_tracker.sv
module rammodel_tracker #(
    parameter int MAX_INFLIGHT = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  rammodel_pkg::axi_ax_t   aw,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  rammodel_pkg::axi_w_t    w,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  rammodel_pkg::axi_ax_t   ar,
    input  logic                    b_valid,
    output logic                    b_ready,
    input  logic                    r_valid,
    output logic                    r_ready,
    input  rammodel_pkg::axi_r_t    r,
    output logic                    areq_valid,
    output rammodel_pkg::mem_areq_t areq,
    output logic                    wreq_valid,
    output rammodel_pkg::mem_wreq_t wreq
);
    import rammodel_pkg::*;

    typedef logic [$clog2(MAX_INFLIGHT+1)-1:0] cnt_t;

    cnt_t      rd_cnt;
    cnt_t      wr_cnt;
    cnt_t      wa_cnt;     // AW bursts still waiting for their data
    logic      aw_acc, ar_acc, w_acc;
    logic      w_done, b_done, r_done;
    logic      hold_valid;
    mem_areq_t hold;

    // The hold slot drains in one cycle, so new requests wait for it
    assign aw_ready = (wr_cnt < cnt_t'(MAX_INFLIGHT)) && !hold_valid;
    assign ar_ready = (rd_cnt < cnt_t'(MAX_INFLIGHT)) && !hold_valid;
    assign w_ready  = wa_cnt != '0;   // Backend needs the address first
    assign b_ready  = 1'b1;
    assign r_ready  = 1'b1;

    assign aw_acc = aw_valid && aw_ready;
    assign ar_acc = ar_valid && ar_ready;
    assign w_acc  = w_valid && w_ready;
    assign w_done = w_acc && w.last;
    assign b_done = b_valid && b_ready;
    assign r_done = r_valid && r_ready && r.last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
            wr_cnt <= '0;
            wa_cnt <= '0;
        end else begin
            case ({ar_acc, r_done})
                2'b10:   rd_cnt <= rd_cnt + 1'b1;
                2'b01:   rd_cnt <= rd_cnt - 1'b1;
                default: rd_cnt <= rd_cnt;
            endcase
            case ({aw_acc, b_done})
                2'b10:   wr_cnt <= wr_cnt + 1'b1;
                2'b01:   wr_cnt <= wr_cnt - 1'b1;
                default: wr_cnt <= wr_cnt;
            endcase
            case ({aw_acc, w_done})
                2'b10:   wa_cnt <= wa_cnt + 1'b1;
                2'b01:   wa_cnt <= wa_cnt - 1'b1;
                default: wa_cnt <= wa_cnt;
            endcase
        end
    end

    // Request strobes, AW ahead of a same-cycle AR
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            areq_valid <= 1'b0;
            hold_valid <= 1'b0;
            wreq_valid <= 1'b0;
        end else begin
            areq_valid <= hold_valid || aw_acc || ar_acc;
            hold_valid <= aw_acc && ar_acc;
            wreq_valid <= w_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_valid) begin
            areq <= hold;
        end else if (aw_acc) begin
            areq <= '{write: 1'b1, ax: aw};
        end else begin
            areq <= '{write: 1'b0, ax: ar};
        end
        hold <= '{write: 1'b0, ax: ar};
        wreq <= w;
    end

endmodule

// File: hw/ready_valid_fork.sv
module ready_valid_fork #(
    parameter int BRANCHES = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                s_valid,
    output logic                s_ready,
    output logic [BRANCHES-1:0] m_valid,
    input  logic [BRANCHES-1:0] m_ready
);

    logic [BRANCHES-1:0] done;     // Branches that took the current item
    logic [BRANCHES-1:0] accept;

    assign m_valid = {BRANCHES{s_valid}} & ~done;
    assign accept  = done | (m_valid & m_ready);
    assign s_ready = &accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= '0;
        end else if (s_valid) begin
            done <= s_ready ? '0 : accept;
        end
    end

endmodule

// File: hw/rammodel_pkg.sv
package rammodel_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [DATA_W/8-1:0] strb_t;
    typedef logic [ID_W-1:0]     id_t;
    typedef logic [7:0]          len_t;   // Beats minus one

    // Shared by AW and AR
    typedef struct packed {
        id_t        id;
        addr_t      addr;
        len_t       len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ax_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        id_t        id;
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        id_t        id;
        data_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    // Address request to the RAM backend
    typedef struct packed {
        logic    write;
        axi_ax_t ax;
    } mem_areq_t;

    typedef axi_w_t mem_wreq_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage
